//--- include/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Operand and result width of every lane
`define ALU_XLEN        64

// Execution lanes behind the dispatcher
`define ALU_NUM_LANES   2
`define ALU_LANE_W      1   // Index width, must cover ALU_NUM_LANES

// Entries in each input and result queue
`define ALU_QUEUE_DEPTH 4

// Tag widths toward the register file and the reorder buffer
`define ALU_PREG_W      6
`define ALU_ROB_PTR_W   5

`endif

//--- design/alu_pkg.sv
`include "alu_macros.svh"

package alu_pkg;

    // ######################################################################
    // Micro-op encoding and issue packet
    // ######################################################################

    typedef enum logic [3:0] {
        UOP_NOP  = 4'd0,
        UOP_ADD  = 4'd1,
        UOP_SUB  = 4'd2,
        UOP_AND  = 4'd3,
        UOP_ORR  = 4'd4,
        UOP_EOR  = 4'd5,
        UOP_MVN  = 4'd6,
        UOP_UBFM = 4'd7,
        UOP_ASR  = 4'd8,
        UOP_MOVZ = 4'd9,
        UOP_MOVK = 4'd10
    } uop_e;

    typedef struct packed {
        uop_e                      uopcode;
        logic [11:0]               imm;       // UBFM imms:immr, MOVZ/MOVK hw in [1:0]
        logic                      set_nzcv;
        logic [`ALU_XLEN-1:0]      r0_val;
        logic [`ALU_XLEN-1:0]      r1_val;
        logic [`ALU_XLEN-1:0]      r2_val;
        logic [3:0]                nzcv_val;  // N Z C V from bit 3 down
        logic [`ALU_PREG_W-1:0]    dest_preg;
        logic [`ALU_PREG_W-1:0]    nzcv_preg;
        logic [`ALU_ROB_PTR_W-1:0] rob_ptr;
    } exec_packet;

    // ######################################################################
    // Writeback side
    // ######################################################################

    typedef struct packed {
        logic                   en;
        logic [`ALU_PREG_W-1:0] index;
        logic [`ALU_XLEN-1:0]   data;
    } reg_write;

    typedef struct packed {
        logic                   en;
        logic [`ALU_PREG_W-1:0] index;
        logic [3:0]             nzcv;
    } nzcv_write;

    typedef struct packed {
        logic                      valid;
        logic [`ALU_ROB_PTR_W-1:0] ptr;
    } rob_done;

    typedef struct packed {
        reg_write  reg_wr;
        nzcv_write nzcv_wr;
        rob_done   done;
    } lane_result;

    // First requester at or after ptr, wrapping around the lanes
    function automatic logic [`ALU_LANE_W-1:0] rr_pick(
        input logic [`ALU_NUM_LANES-1:0] req,
        input logic [`ALU_LANE_W-1:0]    ptr
    );
        logic [`ALU_LANE_W-1:0] pick;
        int                     idx;
        pick = ptr;
        for (int k = `ALU_NUM_LANES - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % `ALU_NUM_LANES;
            if (req[idx]) pick = idx[`ALU_LANE_W-1:0];  // Lowest offset wins
        end
        return pick;
    endfunction

    function automatic logic [`ALU_LANE_W-1:0] rr_next(input logic [`ALU_LANE_W-1:0] ptr);
        return `ALU_LANE_W'((int'(ptr) + 1) % `ALU_NUM_LANES);
    endfunction

endpackage

//--- design/lane_fifo.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module lane_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `ALU_QUEUE_DEPTH
) (
    input  logic clk_in,
    input  logic rst_n,
    input  logic push_valid,
    input  T     push_data,
    output logic push_ready,
    output logic pop_valid,
    output T     pop_data,
    input  logic pop_ready
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];  // Head is read straight from the array
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither leave the fill level alone
            endcase
        end
    end

endmodule

//--- design/alu_dispatch.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_dispatch (
    input  logic                       clk_in,
    input  logic                       rst_n,
    input  logic                       issue_valid,
    input  alu_pkg::exec_packet        issue_pkt,
    output logic                       issue_ready,
    output logic [`ALU_NUM_LANES-1:0]  lane_valid,
    output alu_pkg::exec_packet        lane_pkt,
    input  logic [`ALU_NUM_LANES-1:0]  lane_ready
);
    logic [`ALU_LANE_W-1:0] rr_ptr;
    logic [`ALU_LANE_W-1:0] sel;
    logic                   fire;

    // ######################################################################
    // Lane choice
    // ######################################################################

    // Only lanes whose input queue has room are candidates
    assign sel         = alu_pkg::rr_pick(lane_ready, rr_ptr);
    assign issue_ready = rst_n && (|lane_ready);  // Held low through reset
    assign fire        = issue_valid && issue_ready;

    // Every lane sees the same packet, the valid picks the owner
    assign lane_pkt = issue_pkt;

    always_comb begin
        lane_valid      = '0;
        lane_valid[sel] = fire;
    end

    // ######################################################################
    // Round-robin pointer
    // ######################################################################

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (fire) begin
            rr_ptr <= alu_pkg::rr_next(sel);  // Skip past the lane just used
        end
    end

endmodule

//--- design/alu_lane.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_lane (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                in_valid,
    input  alu_pkg::exec_packet in_pkt,
    output logic                in_ready,
    output logic                out_valid,
    output alu_pkg::lane_result out_res,
    input  logic                out_ready
);
    localparam int MSB = `ALU_XLEN - 1;

    logic [`ALU_XLEN-1:0] r0;
    logic [`ALU_XLEN-1:0] r1;
    logic [`ALU_XLEN-1:0] r2;
    logic [`ALU_XLEN:0]   add_wide;
    logic [5:0]           immr;
    logic [5:0]           imms;
    logic [6:0]           ubfm_w;
    logic [`ALU_XLEN-1:0] ubfm_mask;
    logic [5:0]           mov_sh;
    logic [`ALU_XLEN-1:0] mov_field;
    logic [`ALU_XLEN-1:0] result;
    logic [3:0]           flags;
    alu_pkg::lane_result  res_d;
    logic                 take;

    assign r0 = in_pkt.r0_val;
    assign r1 = in_pkt.r1_val;
    assign r2 = in_pkt.r2_val;

    assign add_wide = {1'b0, r1} + {1'b0, r2};

    // Field width imms-immr+1 runs up to 64, where the shift clears and the mask is all ones
    assign immr      = in_pkt.imm[5:0];
    assign imms      = in_pkt.imm[11:6];
    assign ubfm_w    = 7'(imms) - 7'(immr) + 7'd1;
    assign ubfm_mask = ~({`ALU_XLEN{1'b1}} << ubfm_w);

    assign mov_sh    = {in_pkt.imm[1:0], 4'b0000};  // 16 times hw
    assign mov_field = `ALU_XLEN'(r1[15:0]) << mov_sh;

    // ######################################################################
    // Result and flags
    // ######################################################################

    always_comb begin
        case (in_pkt.uopcode)
            alu_pkg::UOP_ADD:  result = add_wide[MSB:0];
            alu_pkg::UOP_SUB:  result = r1 - r2;
            alu_pkg::UOP_AND:  result = r1 & r2;
            alu_pkg::UOP_ORR:  result = r1 | r2;
            alu_pkg::UOP_EOR:  result = r1 ^ r2;
            alu_pkg::UOP_MVN:  result = ~r1;
            alu_pkg::UOP_UBFM: result = (imms < immr) ? '0 : ((r0 >> immr) & ubfm_mask);
            alu_pkg::UOP_ASR:  result = $signed(r0) >>> r1[5:0];
            alu_pkg::UOP_MOVZ: result = mov_field;
            alu_pkg::UOP_MOVK: result = (r0 & ~(`ALU_XLEN'(16'hffff) << mov_sh)) | mov_field;
            default:           result = '0;
        endcase
    end

    always_comb begin
        flags = in_pkt.nzcv_val;  // C and V pass through unless ADD or SUB
        if (in_pkt.set_nzcv) begin
            flags[3] = result[MSB];
            flags[2] = (result == '0);
            if (in_pkt.uopcode == alu_pkg::UOP_ADD) begin
                flags[1] = add_wide[`ALU_XLEN];
                flags[0] = ~(r1[MSB] ^ r2[MSB]) & (r1[MSB] ^ result[MSB]);
            end else if (in_pkt.uopcode == alu_pkg::UOP_SUB) begin
                flags[1] = (r1 >= r2);  // No borrow
                flags[0] = (r1[MSB] ^ r2[MSB]) & (r1[MSB] ^ result[MSB]);
            end
        end
    end

    always_comb begin
        res_d.reg_wr.en     = 1'b1;
        res_d.reg_wr.index  = in_pkt.dest_preg;
        res_d.reg_wr.data   = result;
        res_d.nzcv_wr.en    = in_pkt.set_nzcv;
        res_d.nzcv_wr.index = in_pkt.nzcv_preg;
        res_d.nzcv_wr.nzcv  = flags;
        res_d.done.valid    = 1'b1;
        res_d.done.ptr      = in_pkt.rob_ptr;
    end

    // ######################################################################
    // Output register
    // ######################################################################

    // Accept a new op when the register is free or drains this cycle
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) out_res <= res_d;
    end

endmodule

//--- design/alu_writeback.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_writeback (
    input  logic                                      clk_in,
    input  logic                                      rst_n,
    input  logic [`ALU_NUM_LANES-1:0]                 q_valid,
    input  alu_pkg::lane_result [`ALU_NUM_LANES-1:0]  q_res,
    output logic [`ALU_NUM_LANES-1:0]                 q_ready,
    output logic                                      commit_valid,
    output alu_pkg::lane_result                       commit,
    input  logic                                      commit_ready
);
    logic [`ALU_LANE_W-1:0] rr_ptr;
    logic [`ALU_LANE_W-1:0] sel;

    // ######################################################################
    // Selection
    // ######################################################################

    assign sel          = alu_pkg::rr_pick(q_valid, rr_ptr);
    assign commit_valid = |q_valid;
    assign commit       = q_res[sel];

    // Pop only the queue whose head is taken this cycle
    always_comb begin
        q_ready      = '0;
        q_ready[sel] = commit_valid && commit_ready;
    end

    // ######################################################################
    // Pointer
    // ######################################################################

    // A stalled commit parks the pointer on the offered lane.
    // That head cannot leave without a pop, so the offer stays put
    // even when an earlier lane fills up meanwhile.
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (commit_valid) begin
            if (commit_ready) begin
                rr_ptr <= alu_pkg::rr_next(sel);  // Next lane gets first chance
            end else begin
                rr_ptr <= sel;
            end
        end
    end

endmodule

//--- design/alu_cluster.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_cluster (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  alu_pkg::exec_packet issue_pkt,
    output logic                issue_ready,
    output logic                commit_valid,
    output alu_pkg::lane_result commit,
    input  logic                commit_ready
);
    // Dispatch to input queues
    logic [`ALU_NUM_LANES-1:0]               disp_valid;
    alu_pkg::exec_packet                     disp_pkt;
    logic [`ALU_NUM_LANES-1:0]               disp_ready;

    // Input queues to lanes
    logic [`ALU_NUM_LANES-1:0]               iq_valid;
    alu_pkg::exec_packet                     iq_pkt [`ALU_NUM_LANES];
    logic [`ALU_NUM_LANES-1:0]               iq_ready;

    // Lanes to result queues
    logic [`ALU_NUM_LANES-1:0]               lr_valid;
    alu_pkg::lane_result                     lr_res [`ALU_NUM_LANES];
    logic [`ALU_NUM_LANES-1:0]               lr_ready;

    // Result queues to writeback
    logic [`ALU_NUM_LANES-1:0]               cq_valid;
    alu_pkg::lane_result [`ALU_NUM_LANES-1:0] cq_res;
    logic [`ALU_NUM_LANES-1:0]               cq_ready;

    alu_dispatch u_dispatch (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .issue_ready (issue_ready),
        .lane_valid  (disp_valid),
        .lane_pkt    (disp_pkt),
        .lane_ready  (disp_ready)
    );

    for (genvar i = 0; i < `ALU_NUM_LANES; i++) begin : g_lane
        lane_fifo #(.T(alu_pkg::exec_packet)) u_in_q (
            .clk_in (clk_in), .rst_n (rst_n),
            .push_valid (disp_valid[i]), .push_data (disp_pkt), .push_ready (disp_ready[i]),
            .pop_valid (iq_valid[i]), .pop_data (iq_pkt[i]), .pop_ready (iq_ready[i])
        );

        alu_lane u_lane (
            .clk_in (clk_in), .rst_n (rst_n),
            .in_valid (iq_valid[i]), .in_pkt (iq_pkt[i]), .in_ready (iq_ready[i]),
            .out_valid (lr_valid[i]), .out_res (lr_res[i]), .out_ready (lr_ready[i])
        );

        lane_fifo #(.T(alu_pkg::lane_result)) u_res_q (
            .clk_in (clk_in), .rst_n (rst_n),
            .push_valid (lr_valid[i]), .push_data (lr_res[i]), .push_ready (lr_ready[i]),
            .pop_valid (cq_valid[i]), .pop_data (cq_res[i]), .pop_ready (cq_ready[i])
        );
    end

    alu_writeback u_writeback (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .q_valid      (cq_valid),
        .q_res        (cq_res),
        .q_ready      (cq_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

//--- verification/alu_cluster_chk.sv
`timescale 1ns/1ps

module alu_cluster_chk (
    input logic                clk_in,
    input logic                rst_n,
    input logic                issue_ready,
    input logic                commit_valid,
    input alu_pkg::lane_result commit,
    input logic                commit_ready
);
    // A stalled commit keeps its valid and its payload
    commit_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit changed while commit_ready was low");

    // All queues are empty after a reset edge
    reset_empty: assert property (@(posedge clk_in) !rst_n |=> !commit_valid)
        else $error("commit_valid high during reset");

    reset_not_ready: assert property (@(posedge clk_in) !rst_n |-> !issue_ready)
        else $error("issue_ready high during reset");

    commit_known: assert property (@(posedge clk_in) disable iff (!rst_n)
        commit_valid |-> !$isunknown(commit))
        else $error("commit holds X while commit_valid is high");

endmodule

bind alu_cluster alu_cluster_chk u_chk (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .issue_ready  (issue_ready),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_ready (commit_ready)
);

//--- verification/alu_cluster_tb.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_cluster_tb;
    localparam int          NUM_OPS   = 400;
    localparam int          ROB_SIZE  = 1 << `ALU_ROB_PTR_W;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                clk_in;
    logic                rst_n;
    logic                issue_valid;
    alu_pkg::exec_packet issue_pkt;
    logic                issue_ready;
    logic                commit_valid;
    alu_pkg::lane_result commit;
    logic                commit_ready;

    logic [31:0]         lfsr = 32'h8c48;
    alu_pkg::lane_result exp_mem [ROB_SIZE];  // Expected result per rob_ptr
    logic [ROB_SIZE-1:0] in_flight;
    logic                pending;
    int                  n_issued;
    int                  n_committed;

    alu_cluster dut (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_pkt    (issue_pkt),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

    initial clk_in = 1'b0;
    always #10 clk_in = ~clk_in;

    // ########################################################################
    // Stimulus
    // ########################################################################

    function automatic logic step_lfsr();
        logic out;
        out  = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (out ? LFSR_TAPS : 32'h0);
        return out;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r[i] = step_lfsr();
        return r;
    endfunction

    // Values around the signed and unsigned overflow points
    function automatic logic [63:0] pick_operand();
        logic [2:0] k;
        if (rand_bits(2) != 0) return rand_bits(64);
        k = 3'(rand_bits(3));
        case (k)
            3'd0:    return 64'h0;
            3'd1:    return 64'h1;
            3'd2:    return 64'h7fff_ffff_ffff_ffff;
            3'd3:    return 64'h8000_0000_0000_0000;
            3'd4:    return 64'hffff_ffff_ffff_ffff;
            3'd5:    return 64'h8000_0000_0000_0001;
            default: return 64'h7fff_ffff_ffff_fffe;
        endcase
    endfunction

    function automatic alu_pkg::exec_packet make_packet(input int seq);
        alu_pkg::exec_packet p;
        p.uopcode   = alu_pkg::uop_e'(4'(rand_bits(4) % 10 + 1));
        p.imm       = 12'(rand_bits(12));
        p.set_nzcv  = rand_bits(1);
        p.r0_val    = pick_operand();
        p.r1_val    = pick_operand();
        p.r2_val    = pick_operand();
        p.nzcv_val  = 4'(rand_bits(4));
        p.dest_preg = `ALU_PREG_W'(rand_bits(`ALU_PREG_W));
        p.nzcv_preg = `ALU_PREG_W'(rand_bits(`ALU_PREG_W));
        p.rob_ptr   = `ALU_ROB_PTR_W'(seq);
        return p;
    endfunction

    // ########################################################################
    // Reference model and checks
    // ########################################################################

    function automatic alu_pkg::lane_result model_result(input alu_pkg::exec_packet p);
        alu_pkg::lane_result e;
        logic [63:0]         r0;
        logic [63:0]         r1;
        logic [63:0]         r2;
        logic [63:0]         res;
        logic [64:0]         wide;
        logic [64:0]         swide;
        logic                c;
        logic                v;
        int                  lo;
        int                  hi;
        int                  hw;
        int                  sh;
        r0  = p.r0_val;
        r1  = p.r1_val;
        r2  = p.r2_val;
        lo  = p.imm[5:0];
        hi  = p.imm[11:6];
        hw  = p.imm[1:0];
        sh  = p.r1_val[5:0];
        res = '0;
        c   = p.nzcv_val[1];  // Kept unless ADD or SUB
        v   = p.nzcv_val[0];
        case (p.uopcode)
            alu_pkg::UOP_ADD: begin
                wide  = {1'b0, r1} + {1'b0, r2};
                swide = {r1[63], r1} + {r2[63], r2};
                res   = wide[63:0];
                c     = wide[64];
                v     = swide[64] ^ swide[63];  // Sign-extended sum leaves 64-bit range
            end
            alu_pkg::UOP_SUB: begin
                wide  = {1'b0, r1} - {1'b0, r2};
                swide = {r1[63], r1} - {r2[63], r2};
                res   = wide[63:0];
                c     = ~wide[64];  // No borrow out of the top bit
                v     = swide[64] ^ swide[63];
            end
            alu_pkg::UOP_AND: res = r1 & r2;
            alu_pkg::UOP_ORR: res = r1 | r2;
            alu_pkg::UOP_EOR: res = r1 ^ r2;
            alu_pkg::UOP_MVN: res = ~r1;
            alu_pkg::UOP_UBFM: begin
                if (hi >= lo) begin
                    for (int b = 0; b <= hi - lo; b++) res[b] = r0[lo + b];
                end
            end
            alu_pkg::UOP_ASR: begin
                for (int b = 0; b < 64; b++) res[b] = (b + sh > 63) ? r0[63] : r0[b + sh];
            end
            alu_pkg::UOP_MOVZ: res[16 * hw +: 16] = r1[15:0];
            alu_pkg::UOP_MOVK: begin
                res = r0;
                res[16 * hw +: 16] = r1[15:0];
            end
            default: res = '0;
        endcase
        e.reg_wr.en     = 1'b1;
        e.reg_wr.index  = p.dest_preg;
        e.reg_wr.data   = res;
        e.nzcv_wr.en    = p.set_nzcv;
        e.nzcv_wr.index = p.nzcv_preg;
        e.nzcv_wr.nzcv  = {res[63], res == 64'h0, c, v};
        e.done.valid    = 1'b1;
        e.done.ptr      = p.rob_ptr;
        return e;
    endfunction

    task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s (got %0h, expected %0h)", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_commit(input alu_pkg::lane_result got);
        alu_pkg::lane_result e;
        int                  ptr;
        ptr = got.done.ptr;
        e   = exp_mem[ptr];
        compare_value(in_flight[ptr], 1'b1, $sformatf("rob %0d committed while not in flight", ptr));
        compare_value(got.done.valid, 1'b1, $sformatf("rob %0d done.valid", ptr));
        compare_value(got.reg_wr.en, 1'b1, $sformatf("rob %0d reg_wr.en", ptr));
        compare_value(got.reg_wr.index, e.reg_wr.index, $sformatf("rob %0d reg_wr.index", ptr));
        compare_value(got.reg_wr.data, e.reg_wr.data, $sformatf("rob %0d reg_wr.data", ptr));
        compare_value(got.nzcv_wr.en, e.nzcv_wr.en, $sformatf("rob %0d nzcv_wr.en", ptr));
        if (e.nzcv_wr.en) begin
            compare_value(got.nzcv_wr.index, e.nzcv_wr.index, $sformatf("rob %0d nzcv index", ptr));
            compare_value(got.nzcv_wr.nzcv, e.nzcv_wr.nzcv, $sformatf("rob %0d nzcv", ptr));
        end
        in_flight[ptr] = 1'b0;
        n_committed++;
    endtask

    // ########################################################################
    // Main sequence and watchdog
    // ########################################################################

    initial begin
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue_pkt    = '0;
        commit_ready = 1'b0;
        in_flight    = '0;
        pending      = 1'b0;
        n_issued     = 0;
        n_committed  = 0;
        repeat (3) @(posedge clk_in);
        #1 rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk_in);
            compare_value(commit_valid, 1'b0, "commit_valid high before the first issue");
        end
        while (n_committed < NUM_OPS) begin
            @(posedge clk_in);
            #1;
            // A rob_ptr is reused only once its earlier owner has committed
            if (!pending && n_issued < NUM_OPS && !in_flight[n_issued % ROB_SIZE]
                    && rand_bits(2) != 0) begin
                issue_pkt = make_packet(n_issued % ROB_SIZE);
                pending   = 1'b1;
            end
            issue_valid  = pending;
            commit_ready = rand_bits(1);
            @(negedge clk_in);  // Sampled here, the transfers land on the next edge
            if (commit_valid && commit_ready) check_commit(commit);
            else if (n_issued == 0) compare_value(commit_valid, 1'b0, "commit without any issue");
            if (issue_valid && issue_ready) begin
                exp_mem[issue_pkt.rob_ptr]   = model_result(issue_pkt);
                in_flight[issue_pkt.rob_ptr] = 1'b1;
                n_issued++;
                pending = 1'b0;
            end
        end
        repeat (5) begin
            @(posedge clk_in);
            #1 commit_ready = 1'b1;
            @(negedge clk_in);
            compare_value(commit_valid, 1'b0, "commit_valid high after the last commit");
        end
        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 40) @(posedge clk_in);
        $display("Timeout after %0d cycles, only %0d of %0d micro-ops committed",
                 NUM_OPS * 40, n_committed, NUM_OPS);
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

//--- build.f
+incdir+include
design/alu_pkg.sv
design/lane_fifo.sv
design/alu_dispatch.sv
design/alu_lane.sv
design/alu_writeback.sv
design/alu_cluster.sv
verification/alu_cluster_chk.sv
verification/alu_cluster_tb.sv

//--- Bender.yml
package:
  name: alu_cluster

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/alu_pkg.sv
      - design/lane_fifo.sv
      - design/alu_dispatch.sv
      - design/alu_lane.sv
      - design/alu_writeback.sv
      - design/alu_cluster.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/alu_cluster_chk.sv
      - verification/alu_cluster_tb.sv
